// File: fb_display.f
fb_pkg.sv
display_timing.sv
render_rect.sv
bitmap_addr.sv
bram_sdp.sv
linebuffer.sv
paint_out.sv
fb_display_top.sv
tb_fb_display.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the framebuffer display testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module tb_fb_display \
    --Mdir obj_dir \
    -o tb_fb_display \
    -f fb_display.f

./obj_dir/tb_fb_display | tee "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
    echo "run failed, see $LOG"
    exit 1
fi

echo "run passed"
exit 0

// File: tb_fb_display.sv
// testbench for the framebuffer display top
// changes the rectangle once per test and checks a whole output frame against a reference
module tb_fb_display;

    localparam int frame_cycles = fb_pkg::h_total * fb_pkg::v_total;
    localparam int num_tests    = 6;
    // change, skip and check frame per test plus one more for startup
    localparam int max_cycles   = (num_tests + 1) * 3 * frame_cycles + 2000;
    localparam int fb_x_end     = fb_pkg::fb_offx + fb_pkg::fb_width * fb_pkg::fb_scale;
    localparam int fb_y_end     = fb_pkg::fb_offy + fb_pkg::fb_height * fb_pkg::fb_scale;

    logic             clk_sys = 1'b0;
    logic             rst_sys = 1'b1;
    fb_pkg::rect_t    rect;
    logic             busy;
    fb_pkg::rgb_out_t pix;

    fb_pkg::rect_t ref_rect;           // rect of the frame under check
    string         test_name = "startup";
    logic          armed      = 1'b0;  // start checking at the next frame pulse
    logic          checking   = 1'b0;
    logic          done       = 1'b0;  // checked frame finished
    logic          chk_timing = 1'b0;  // busy checks on
    logic          busy_q     = 1'b0;
    logic          ex_de;
    int            ex_sx      = 0;     // expected output position
    int            ex_sy      = 0;
    int            rises      = 0;     // busy rising edges in the frame
    int            test_errs  = 0;
    int            total_errs = 0;
    int            test_num   = 0;
    int            tests_ok   = 0;
    int            tests_bad  = 0;
    int            cycles     = 0;

    always #4 clk_sys = ~clk_sys;  // period 8

    fb_display_top dut_i (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys),
        .rect    (rect),
        .busy    (busy),
        .pix     (pix)
    );

    // expected colour with 8 bits per channel
    function automatic logic [23:0] expected_rgb(input int sx, input int sy, input logic de,
                                                 input fb_pkg::rect_t r);
        int         fx;
        int         fy;
        logic [3:0] idx;
        logic [11:0] c;
        if (!de) return 24'h0;  // blanking
        if (sx < fb_pkg::fb_offx || sx >= fb_x_end || sy < fb_pkg::fb_offy || sy >= fb_y_end) begin
            c = fb_pkg::bg_colr;
        end else begin
            fx = (sx - fb_pkg::fb_offx) / fb_pkg::fb_scale;  // fb pixel under the screen pixel
            fy = (sy - fb_pkg::fb_offy) / fb_pkg::fb_scale;
            if (fx >= r.x0 && fx <= r.x1 && fy >= r.y0 && fy <= r.y1) idx = r.cidx;
            else idx = 4'd0;  // cleared
            c = {idx, 4'd15 - idx, idx ^ 4'd5};  // red i, green 15-i, blue i xor 5
        end
        return {{2{c[11:8]}}, {2{c[7:4]}}, {2{c[3:0]}}};
    endfunction

    function automatic fb_pkg::rect_t make_rect(input int x0, input int y0, input int x1,
                                                input int y1, input logic [3:0] c);
        fb_pkg::rect_t r;
        r.x0   = fb_pkg::coord_t'(x0);
        r.y0   = fb_pkg::coord_t'(y0);
        r.x1   = fb_pkg::coord_t'(x1);
        r.y1   = fb_pkg::coord_t'(y1);
        r.cidx = c;
        return r;
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s at %0d,%0d: expected %0h, actual %0h",
                     test_name, what, ex_sx, ex_sy, expected, actual);
            test_errs++;
            total_errs++;
        end
    endtask

    task automatic wait_frame_pulse();
        do @(negedge clk_sys); while (pix.frame !== 1'b1);
    endtask

    // new rect after an output frame pulse then skip a frame and check the next
    task automatic run_test(input string name, input fb_pkg::rect_t r, input logic timing);
        wait_frame_pulse();
        rect = r;
        @(negedge clk_sys);  // past the pulse
        ref_rect   = r;
        test_name  = name;
        chk_timing = timing;
        test_errs  = 0;
        armed      = 1'b1;
        wait (done);
        done = 1'b0;
        test_num++;
        if (test_errs == 0) begin
            tests_ok++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d mismatches", test_num, name, test_errs);
        end
    endtask

    // compare on the falling edge where outputs are settled
    always @(negedge clk_sys) begin
        if (checking && busy && !busy_q) rises++;
        busy_q = busy;
        if (!checking && armed && pix.frame === 1'b1) begin
            checking = 1'b1;  // frame start
            armed    = 1'b0;
            ex_sx    = 0;
            ex_sy    = 0;
            rises    = 0;
        end
        if (checking) begin
            ex_de = (ex_sx < fb_pkg::h_active) && (ex_sy < fb_pkg::v_active);
            check("sx", 32'(ex_sx), 32'(pix.sx));
            check("sy", 32'(ex_sy), 32'(pix.sy));
            check("de", 32'(ex_de), 32'(pix.de));
            check("frame", 32'(ex_sx == 0 && ex_sy == 0), 32'(pix.frame));
            check("rgb", 32'(expected_rgb(ex_sx, ex_sy, ex_de, ref_rect)),
                  32'({pix.r, pix.g, pix.b}));
            if (chk_timing && ex_sx == 0 && ex_sy == 4) begin
                check("busy at line 4", 32'd0, 32'(busy));  // render of last frame over
            end
            if (ex_sx == fb_pkg::h_total - 1) begin
                ex_sx = 0;
                if (ex_sy == fb_pkg::v_total - 1) begin
                    if (chk_timing) check("busy rises", 32'd1, 32'(rises));
                    checking = 1'b0;  // whole frame seen
                    done     = 1'b1;
                end else begin
                    ex_sy++;
                end
            end else begin
                ex_sx++;
            end
        end
    end

    // timeout
    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk_sys);
            cycles++;
        end
        $display("timeout after %0d cycles in test %s", cycles, test_name);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rect = make_rect(1, 0, 0, 0, 4'd7);  // empty
        repeat (2) @(negedge clk_sys);
        rst_sys = 1'b0;
        run_test("empty after reset", make_rect(1, 0, 0, 0, 4'd7), 1'b0);
        run_test("inside buffer", make_rect(5, 3, 12, 9, 4'd10), 1'b0);
        run_test("clipped on all edges", make_rect(-4, -3, 35, 22, 4'd12), 1'b0);
        run_test("replace old rect", make_rect(2, 14, 5, 17, 4'd3), 1'b0);
        run_test("corner pixel", make_rect(31, 19, 31, 19, 4'd15), 1'b0);
        run_test("raster and busy", make_rect(-6, -4, 39, 23, 4'd9), 1'b1);
        $display("tests run %0d, ok %0d, failed %0d, mismatches %0d",
                 test_num, tests_ok, tests_bad, total_errs);
        if (tests_bad == 0 && total_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: fb_display_top.sv
// framebuffer display top
// timing, rectangle render into the framebuffer, linebuffer readout and paint
module fb_display_top (
    input  logic             clk_sys,
    input  logic             rst_sys,
    input  fb_pkg::rect_t    rect,
    output logic             busy,
    output fb_pkg::rgb_out_t pix  // 3 cycles behind the raster
);

    fb_pkg::scan_t                 scan;
    logic                          draw_start;
    fb_pkg::draw_px_t              draw_px;
    logic [fb_pkg::fb_addrw-1:0]   fb_addr_write;
    logic [fb_pkg::fb_addrw-1:0]   fb_addr_read;
    fb_pkg::cidx_t                 fb_cidx_write;
    fb_pkg::cidx_t                 fb_cidx_read;
    logic                          fb_we;
    fb_pkg::cidx_t                 lb_cidx;

    display_timing timing_i (
        .clk_sys    (clk_sys),
        .rst_sys    (rst_sys),
        .scan       (scan),
        .draw_start (draw_start)
    );

    render_rect render_i (
        .clk_sys    (clk_sys),
        .rst_sys    (rst_sys),
        .draw_start (draw_start),
        .rect       (rect),
        .px         (draw_px),
        .busy       (busy)
    );

    // pixel to address, write enable already clipped
    bitmap_addr addr_i (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys),
        .px      (draw_px),
        .addr    (fb_addr_write),
        .cidx    (fb_cidx_write),
        .we      (fb_we)
    );

    // 32x20 framebuffer, single buffered
    bram_sdp #(
        .entry_t (fb_pkg::cidx_t),
        .depth   (fb_pkg::fb_pixels)
    ) fb_mem_i (
        .clk_sys    (clk_sys),
        .we         (fb_we),
        .addr_write (fb_addr_write),
        .data_in    (fb_cidx_write),
        .addr_read  (fb_addr_read),
        .data_out   (fb_cidx_read)
    );

    linebuffer lb_i (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys),
        .scan    (scan),
        .fb_addr (fb_addr_read),
        .fb_data (fb_cidx_read),
        .cidx    (lb_cidx)
    );

    paint_out paint_i (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys),
        .scan    (scan),
        .cidx    (lb_cidx),
        .pix     (pix)
    );

endmodule

// File: paint_out.sv
// paint stage, palette lookup then registered rgb output
// background outside the fb area, black in blanking, 4-bit channels doubled to 8
module paint_out (
    input  logic             clk_sys,
    input  logic             rst_sys,
    input  fb_pkg::scan_t    scan,
    input  fb_pkg::cidx_t    cidx,  // one cycle behind scan
    output fb_pkg::rgb_out_t pix
);

    fb_pkg::scan_t s1;        // lines up with cidx
    fb_pkg::scan_t s2;        // lines up with colr
    fb_pkg::colr_t colr;
    fb_pkg::colr_t colr_sel;
    logic          in_fb;

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            s1 <= '0;
            s2 <= '0;
        end else begin
            s1 <= scan;
            s2 <= s1;
        end
    end

    always_ff @(posedge clk_sys) colr <= fb_pkg::palette[cidx];  // lookup

    always_comb begin
        in_fb = (s2.sx >= fb_pkg::fb_offx)
            && (s2.sx < fb_pkg::fb_offx + fb_pkg::fb_width * fb_pkg::fb_scale)
            && (s2.sy >= fb_pkg::fb_offy)
            && (s2.sy < fb_pkg::fb_offy + fb_pkg::fb_height * fb_pkg::fb_scale);
        if (!s2.de) colr_sel = '0;
        else if (in_fb) colr_sel = colr;
        else colr_sel = fb_pkg::bg_colr;
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            pix <= '0;
        end else begin
            pix.sx    <= s2.sx;
            pix.sy    <= s2.sy;
            pix.de    <= s2.de;
            pix.frame <= s2.frame;
            pix.r     <= {2{colr_sel[11:8]}};
            pix.g     <= {2{colr_sel[7:4]}};
            pix.b     <= {2{colr_sel[3:0]}};
        end
    end

endmodule

// File: linebuffer.sv
// ping-pong linebuffer
// prefetches one framebuffer row per line into the idle bank, plays it out at scale 2
module linebuffer (
    input  logic                        clk_sys,
    input  logic                        rst_sys,
    input  fb_pkg::scan_t               scan,
    output logic [fb_pkg::fb_addrw-1:0] fb_addr,
    input  fb_pkg::cidx_t               fb_data,  // one cycle after fb_addr
    output fb_pkg::cidx_t               cidx
);

    logic [$clog2(fb_pkg::fb_width)-1:0]  fill_col;    // fb column being read
    logic [$clog2(fb_pkg::fb_width)-1:0]  fill_col_q;  // matches fb_data
    logic [$clog2(fb_pkg::fb_height)-1:0] fill_row;
    logic                                 fill_act;    // read in progress
    logic                                 fill_we;
    logic                                 rd_bank;     // bank shown this line
    logic                                 rd_bank_q;
    fb_pkg::coord_t                       next_sy;
    fb_pkg::coord_t                       next_row;
    logic                                 next_in_fb;
    fb_pkg::coord_t                       rd_x;        // scaled read column
    fb_pkg::cidx_t                        bank0_q;
    fb_pkg::cidx_t                        bank1_q;

    // look at the line that follows this one
    always_comb begin
        if (scan.sy == fb_pkg::coord_t'(fb_pkg::v_total - 1)) next_sy = '0;
        else next_sy = fb_pkg::coord_t'(scan.sy + 1);
        next_in_fb = (next_sy >= fb_pkg::fb_offy)
            && (next_sy < fb_pkg::fb_offy + fb_pkg::fb_height * fb_pkg::fb_scale);
        next_row = fb_pkg::coord_t'((next_sy - fb_pkg::coord_t'(fb_pkg::fb_offy))
            / fb_pkg::coord_t'(fb_pkg::fb_scale));
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            rd_bank   <= 1'b0;
            rd_bank_q <= 1'b0;
            fill_act  <= 1'b0;
            fill_we   <= 1'b0;
            fill_col  <= '0;
        end else begin
            rd_bank_q <= rd_bank;
            fill_we   <= fill_act;  // ram read latency
            if (scan.line) begin
                rd_bank <= ~rd_bank;  // swap at line start
                if (next_in_fb) begin
                    fill_act <= 1'b1;
                    fill_col <= '0;
                end
            end else if (fill_act) begin
                if (fill_col == ($clog2(fb_pkg::fb_width))'(fb_pkg::fb_width - 1)) begin
                    fill_act <= 1'b0;  // whole row read
                end
                fill_col <= fill_col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        fill_col_q <= fill_col;
        if (scan.line && next_in_fb) fill_row <= ($clog2(fb_pkg::fb_height))'(next_row);
    end

    always_comb fb_addr = fb_pkg::fb_addrw'(fill_row * fb_pkg::fb_width)
        + fb_pkg::fb_addrw'(fill_col);

    // column (sx - offx) / scale, junk outside the fb area
    always_comb rd_x = fb_pkg::coord_t'((scan.sx - fb_pkg::coord_t'(fb_pkg::fb_offx))
        / fb_pkg::coord_t'(fb_pkg::fb_scale));

    // write goes to the bank not on show
    bram_sdp #(
        .entry_t (fb_pkg::cidx_t),
        .depth   (fb_pkg::fb_width)
    ) bank0_i (
        .clk_sys    (clk_sys),
        .we         (fill_we && rd_bank),
        .addr_write (fill_col_q),
        .data_in    (fb_data),
        .addr_read  (rd_x[$clog2(fb_pkg::fb_width)-1:0]),
        .data_out   (bank0_q)
    );

    bram_sdp #(
        .entry_t (fb_pkg::cidx_t),
        .depth   (fb_pkg::fb_width)
    ) bank1_i (
        .clk_sys    (clk_sys),
        .we         (fill_we && !rd_bank),
        .addr_write (fill_col_q),
        .data_in    (fb_data),
        .addr_read  (rd_x[$clog2(fb_pkg::fb_width)-1:0]),
        .data_out   (bank1_q)
    );

    always_comb cidx = rd_bank_q ? bank1_q : bank0_q;  // select lines up with ram data

endmodule

// File: bram_sdp.sv
// simple dual-port ram, one write port and one registered read port
// entry type is a parameter so one block serves framebuffer and linebuffer
module bram_sdp #(
    parameter type entry_t = logic [7:0],
    parameter int  depth   = 256
) (
    input  logic                     clk_sys,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] addr_write,
    input  entry_t                   data_in,
    input  logic [$clog2(depth)-1:0] addr_read,
    output entry_t                   data_out
);

    entry_t mem [depth];

    always_ff @(posedge clk_sys) begin
        if (we) mem[addr_write] <= data_in;
    end

    // one cycle read latency
    always_ff @(posedge clk_sys) begin
        data_out <= mem[addr_read];
    end

endmodule

// File: bitmap_addr.sv
// framebuffer address pipeline, three stages
// clips off-buffer pixels and turns x,y into a linear address
module bitmap_addr (
    input  logic                         clk_sys,
    input  logic                         rst_sys,
    input  fb_pkg::draw_px_t             px,
    output logic [fb_pkg::fb_addrw-1:0]  addr,
    output fb_pkg::cidx_t                cidx,
    output logic                         we
);

    logic [fb_pkg::lat_addr-1:0] vld_sr;  // valid delay line
    fb_pkg::coord_t              row1;
    fb_pkg::coord_t              x1;
    fb_pkg::coord_t              x2;
    fb_pkg::coord_t              prod2;   // row * width
    fb_pkg::cidx_t               cidx1;
    fb_pkg::cidx_t               cidx2;
    logic                        clip1;
    logic                        clip2;
    logic                        clip3;

    always_ff @(posedge clk_sys) begin
        if (rst_sys) vld_sr <= '0;
        else vld_sr <= {vld_sr[fb_pkg::lat_addr-2:0], px.valid};
    end

    // stage 1, clip test and row
    always_ff @(posedge clk_sys) begin
        clip1 <= (px.x < 0) || (px.x >= fb_pkg::fb_width)
              || (px.y < 0) || (px.y >= fb_pkg::fb_height);
        row1  <= px.y;
        x1    <= px.x;
        cidx1 <= px.cidx;
    end

    // stage 2, row offset
    always_ff @(posedge clk_sys) begin
        prod2 <= fb_pkg::coord_t'(row1 * fb_pkg::fb_width);  // garbage if clipped
        x2    <= x1;
        cidx2 <= cidx1;
        clip2 <= clip1;
    end

    // stage 3, add column
    always_ff @(posedge clk_sys) begin
        addr  <= fb_pkg::fb_addrw'(prod2 + x2);
        cidx  <= cidx2;
        clip3 <= clip2;
    end

    always_comb we = vld_sr[fb_pkg::lat_addr-1] && !clip3;  // no write when clipped

endmodule

// File: render_rect.sv
// rectangle renderer
// clears the whole framebuffer, then walks one rectangle, one pixel per cycle
module render_rect (
    input  logic             clk_sys,
    input  logic             rst_sys,
    input  logic             draw_start,
    input  fb_pkg::rect_t    rect,
    output fb_pkg::draw_px_t px,
    output logic             busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_clear,
        st_fill
    } state_t;

    state_t         state;
    fb_pkg::rect_t  r;      // latched at draw_start
    fb_pkg::coord_t x;      // walk position, shared by clear and fill
    fb_pkg::coord_t y;
    logic           empty;  // nothing to fill

    always_comb empty = (r.x1 < r.x0) || (r.y1 < r.y0);

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state <= st_idle;
            x     <= '0;
            y     <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (draw_start) begin  // starts while busy are dropped
                        r     <= rect;
                        x     <= '0;
                        y     <= '0;
                        state <= st_clear;
                    end
                end
                st_clear: begin
                    if (x == fb_pkg::coord_t'(fb_pkg::fb_width - 1)) begin
                        x <= '0;
                        if (y == fb_pkg::coord_t'(fb_pkg::fb_height - 1)) begin
                            // buffer cleared, move to the rectangle
                            x     <= r.x0;
                            y     <= r.y0;
                            state <= empty ? st_idle : st_fill;
                        end else begin
                            y <= y + 1'b1;
                        end
                    end else begin
                        x <= x + 1'b1;
                    end
                end
                st_fill: begin
                    if (x == r.x1) begin
                        x <= r.x0;  // back to left edge
                        if (y == r.y1) begin
                            state <= st_idle;  // last pixel
                        end else begin
                            y <= y + 1'b1;
                        end
                    end else begin
                        x <= x + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // pixel out follows the walk directly
    always_comb begin
        px.x     = x;
        px.y     = y;
        px.cidx  = (state == st_fill) ? r.cidx : fb_pkg::clear_cidx;
        px.valid = (state != st_idle);
        busy     = (state != st_idle);
    end

endmodule

// File: display_timing.sv
// display timing, raster counters for the 80x50 active area in a 100x62 frame
// flags are registered together with the coordinates they belong to
module display_timing (
    input  logic          clk_sys,
    input  logic          rst_sys,
    output fb_pkg::scan_t scan,
    output logic          draw_start  // start of render line
);

    fb_pkg::coord_t nx;  // next position
    fb_pkg::coord_t ny;
    logic           n_de;

    // step the raster
    always_comb begin
        nx = fb_pkg::coord_t'(scan.sx + 1);
        ny = scan.sy;
        if (scan.sx == fb_pkg::coord_t'(fb_pkg::h_total - 1)) begin
            nx = '0;  // wrap line
            if (scan.sy == fb_pkg::coord_t'(fb_pkg::v_total - 1)) begin
                ny = '0;  // wrap frame
            end else begin
                ny = fb_pkg::coord_t'(scan.sy + 1);
            end
        end
        n_de = (nx < fb_pkg::h_active) && (ny < fb_pkg::v_active);
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            scan.sx    <= '0;
            scan.sy    <= '0;
            scan.de    <= 1'b1;  // 0,0 is active
            scan.frame <= 1'b0;
            scan.line  <= 1'b0;
            draw_start <= 1'b0;
        end else begin
            scan.sx    <= nx;
            scan.sy    <= ny;
            scan.de    <= n_de;
            scan.frame <= (nx == 0) && (ny == 0);
            scan.line  <= (nx == 0);  // every line, blanking too
            // render begins once the fb area has been shown
            draw_start <= (nx == 0) && (ny == fb_pkg::coord_t'(fb_pkg::draw_line));
        end
    end

endmodule

// File: fb_pkg.sv
// framebuffer display package
// geometry, colour types, palette table and the structs shared between blocks
package fb_pkg;

    localparam int cordw = 16;  // signed coordinate width

    // raster, active area inside total
    localparam int h_active = 80;
    localparam int h_total  = 100;
    localparam int v_active = 50;
    localparam int v_total  = 62;

    // framebuffer geometry and placement on screen
    localparam int fb_width  = 32;
    localparam int fb_height = 20;
    localparam int fb_scale  = 2;
    localparam int fb_offx   = 8;  // screen x 8..71
    localparam int fb_offy   = 5;  // screen y 5..44
    localparam int fb_pixels = fb_width * fb_height;
    localparam int fb_addrw  = $clog2(fb_pixels);

    localparam int draw_line = 45;  // render starts here, after fb area
    localparam int lat_addr  = 3;   // address pipeline depth

    typedef logic [3:0] cidx_t;   // colour index
    typedef logic [11:0] colr_t;  // 4 bits each of r, g, b
    typedef logic signed [cordw-1:0] coord_t;

    // red i, green 15-i, blue i xor 5
    localparam colr_t palette [16] = '{
        12'h0F5, 12'h1E4, 12'h2D7, 12'h3C6,
        12'h4B1, 12'h5A0, 12'h693, 12'h782,
        12'h87D, 12'h96C, 12'hA5F, 12'hB4E,
        12'hC39, 12'hD28, 12'hE1B, 12'hF0A
    };

    localparam colr_t bg_colr    = 12'h137;  // outside the fb area
    localparam cidx_t clear_cidx = 4'd0;

    // rectangle, corners inclusive, may lie off the buffer
    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        cidx_t  cidx;
    } rect_t;

    // raster position and flags
    typedef struct packed {
        coord_t sx;
        coord_t sy;
        logic   de;     // active area
        logic   frame;  // pulse at 0,0
        logic   line;   // pulse at sx 0
    } scan_t;

    // one pixel from the renderer
    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
        logic   valid;
    } draw_px_t;

    // display output, 8 bits per channel
    typedef struct packed {
        coord_t     sx;
        coord_t     sy;
        logic       de;
        logic       frame;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_out_t;

endpackage
